//--- bench/bpred_cases.svh
`ifndef bpred_cases_svh
`define bpred_cases_svh

// columns: test id, fetch_en, resolve strobe, resolve record, expected fetch
// resolve record: pc, target, taken, pred_taken, pred_target
// expected fetch: pc, pred_taken, pred_target, sampled just before the next edge
typedef struct packed {
  logic [2:0]            test_id;
  logic                  fetch_en;
  logic                  res_strobe;
  bpred_pkg::resolve_t   res;
  logic [addr_width-1:0] exp_pc;
  logic                  exp_taken;
  logic [addr_width-1:0] exp_target;
} case_row_t;

localparam int num_rows = 48;

case_row_t cases [num_rows] = '{
  '{3'd1, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h000, 1'b0, 32'h000},
  '{3'd1, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h004, 1'b0, 32'h000},
  '{3'd1, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h008, 1'b0, 32'h000},
  '{3'd1, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h00c, 1'b0, 32'h000},
  '{3'd1, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h00c, 1'b0, 32'h000},
  '{3'd1, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h00c, 1'b0, 32'h000},
  // taken branch at 0x20 that nobody predicted, loops back to 0x08
  '{3'd2, 1'b0, 1'b1, '{32'h020, 32'h008, 1'b1, 1'b0, 32'h000}, 32'h010, 1'b0, 32'h000},
  '{3'd2, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h010, 1'b0, 32'h000},
  '{3'd2, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h008, 1'b0, 32'h000},
  '{3'd2, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h00c, 1'b0, 32'h000},
  '{3'd2, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h010, 1'b0, 32'h000},
  '{3'd2, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h014, 1'b0, 32'h000},
  '{3'd2, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h018, 1'b0, 32'h000},
  '{3'd2, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h01c, 1'b0, 32'h000},
  '{3'd2, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b1, 32'h008},
  // two not-taken outcomes, the 0x40 target must never be stored
  '{3'd3, 1'b0, 1'b1, '{32'h020, 32'h040, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b1, 32'h008},
  '{3'd3, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b1, 32'h008},
  '{3'd3, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b1, 32'h008},
  '{3'd3, 1'b0, 1'b1, '{32'h020, 32'h040, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b1, 32'h008},
  '{3'd3, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b1, 32'h008},
  '{3'd3, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b0, 32'h008},
  // new target 0x18 sits just before the branch, so the loop comes back to it
  '{3'd4, 1'b0, 1'b1, '{32'h020, 32'h018, 1'b1, 1'b0, 32'h000}, 32'h020, 1'b0, 32'h008},
  '{3'd4, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b0, 32'h008},
  '{3'd4, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h018, 1'b0, 32'h000},
  '{3'd4, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h01c, 1'b0, 32'h000},
  '{3'd4, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b1, 32'h018},
  '{3'd4, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h018, 1'b0, 32'h000},
  // steer to 0x100, then chain 0x100..0x170 back to 0x18, last one evicts 0x20
  '{3'd5, 1'b0, 1'b1, '{32'h020, 32'h100, 1'b1, 1'b0, 32'h000}, 32'h018, 1'b0, 32'h000},
  '{3'd5, 1'b0, 1'b1, '{32'h100, 32'h110, 1'b1, 1'b1, 32'h110}, 32'h018, 1'b0, 32'h000},
  '{3'd5, 1'b0, 1'b1, '{32'h110, 32'h120, 1'b1, 1'b1, 32'h120}, 32'h100, 1'b0, 32'h000},
  '{3'd5, 1'b0, 1'b1, '{32'h120, 32'h130, 1'b1, 1'b1, 32'h130}, 32'h100, 1'b1, 32'h110},
  '{3'd5, 1'b0, 1'b1, '{32'h130, 32'h140, 1'b1, 1'b1, 32'h140}, 32'h100, 1'b1, 32'h110},
  '{3'd5, 1'b0, 1'b1, '{32'h140, 32'h150, 1'b1, 1'b1, 32'h150}, 32'h100, 1'b1, 32'h110},
  '{3'd5, 1'b0, 1'b1, '{32'h150, 32'h160, 1'b1, 1'b1, 32'h160}, 32'h100, 1'b1, 32'h110},
  '{3'd5, 1'b0, 1'b1, '{32'h160, 32'h170, 1'b1, 1'b1, 32'h170}, 32'h100, 1'b1, 32'h110},
  '{3'd5, 1'b0, 1'b1, '{32'h170, 32'h018, 1'b1, 1'b1, 32'h018}, 32'h100, 1'b1, 32'h110},
  '{3'd5, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h100, 1'b1, 32'h110},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h100, 1'b1, 32'h110},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h110, 1'b1, 32'h120},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h120, 1'b1, 32'h130},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h130, 1'b1, 32'h140},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h140, 1'b1, 32'h150},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h150, 1'b1, 32'h160},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h160, 1'b1, 32'h170},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h170, 1'b1, 32'h018},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h018, 1'b0, 32'h000},
  '{3'd5, 1'b1, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h01c, 1'b0, 32'h000},
  '{3'd5, 1'b0, 1'b0, '{32'h000, 32'h000, 1'b0, 1'b0, 32'h000}, 32'h020, 1'b0, 32'h000}
};

`endif

//--- bench/bpred_tb.sv
`timescale 1ns/1ps

module bpred_tb;

  localparam int addr_width = bpred_pkg::default_addr_width;
  localparam int entries = 8;
  localparam logic [addr_width-1:0] start_pc = '0;
  localparam int clk_period = 8;
  localparam int drive_delay = 1;
  localparam int random_steps = 200;

  logic                clk;
  logic                reset;
  logic                fetch_en;
  logic                resolve_strobe;
  bpred_pkg::resolve_t resolve;
  logic                fetch_strobe;
  bpred_pkg::fetch_t   fetch;

  int     pass_count;
  int     fail_count;
  integer seed;

  // reference model, counters 0..3 with 2 and up predicting taken
  logic [addr_width-1:0] m_keys    [entries];
  logic [addr_width-1:0] m_targets [entries];
  int                    m_counter [entries];
  logic                  m_used    [entries];
  int                    m_ptr;
  logic [addr_width-1:0] m_pc;
  logic                  m_upd_valid;
  bpred_pkg::update_t    m_upd;
  logic                  m_redir_valid;
  logic [addr_width-1:0] m_redir_pc;

  `include "bpred_cases.svh"

  string test_names [1:6] = '{"reset and sequential fetch", "mispredict redirect and allocation",
                              "counter hysteresis", "target rewrite", "round-robin replacement",
                              "random stream"};

  bpred_top #(
    .addr_width (addr_width),
    .entries    (entries),
    .reset_pc   (start_pc)
  ) dut0 (
    .clk            (clk),
    .reset          (reset),
    .fetch_en       (fetch_en),
    .resolve_strobe (resolve_strobe),
    .resolve        (resolve),
    .fetch_strobe   (fetch_strobe),
    .fetch          (fetch)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // watchdog sized from the table, the random stream and some slack
  initial begin
    #((num_rows + random_steps + 20) * clk_period);
    $display("timeout: the run did not reach its end in time");
    $display("Finished with errors");
    $finish;
  end

  task automatic check_field(input string field, input int step, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("mismatch %s at step %0d: expected %h, actual %h", field, step, expected, actual);
    end
  endtask

  task automatic check_fetch(input int step, input logic [addr_width-1:0] pc, input logic taken,
                             input logic [addr_width-1:0] target);
    check_field("fetch_strobe", step, 32'(fetch_strobe), 32'(fetch_en));
    check_field("fetch.pc", step, fetch.pc, pc);
    check_field("fetch.pred_taken", step, 32'(fetch.pred_taken), 32'(taken));
    check_field("fetch.pred_target", step, fetch.pred_target, target);
  endtask

  task automatic report_test(input int id, input int errors_before);
    if (fail_count == errors_before) begin
      $display("test %0d %s: ok", id, test_names[id]);
    end else begin
      $display("test %0d %s: %0d errors", id, test_names[id], fail_count - errors_before);
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    fetch_en = 1'b0;
    resolve_strobe = 1'b0;
    resolve = '0;
    repeat (4) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
  endtask

  // lowest occupied entry with this key, -1 on a miss
  function automatic int model_find(input logic [addr_width-1:0] pc);
    int found;
    found = -1;
    for (int i = entries - 1; i >= 0; i--) begin
      if (m_used[i] && m_keys[i] == pc) found = i;
    end
    return found;
  endfunction

  task automatic model_predict(input logic [addr_width-1:0] pc, output logic taken,
                               output logic [addr_width-1:0] target);
    int idx;
    idx = model_find(pc);
    taken = (idx >= 0) && (m_counter[idx] >= 2);
    target = (idx >= 0) ? m_targets[idx] : '0;
  endtask

  task automatic model_reset();
    for (int i = 0; i < entries; i++) begin
      m_used[i] = 1'b0;
      m_counter[i] = 0;
    end
    m_ptr = 0;
    m_pc = start_pc;
    m_upd_valid = 1'b0;
    m_redir_valid = 1'b0;
  endtask

  // one clock edge: pc, then the table write, then the resolve registers
  task automatic model_step(input logic en, input logic strobe, input bpred_pkg::resolve_t res);
    logic                  pt;
    logic [addr_width-1:0] ptgt;
    logic [addr_width-1:0] correct;
    logic [addr_width-1:0] guessed;
    int                    idx;
    model_predict(m_pc, pt, ptgt);
    if (m_redir_valid) begin
      m_pc = m_redir_pc;
    end else if (en) begin
      m_pc = pt ? ptgt : m_pc + 4;
    end
    if (m_upd_valid) begin
      idx = model_find(m_upd.key);
      if (idx >= 0 && m_upd.taken) begin
        m_counter[idx] = (m_counter[idx] < 3) ? m_counter[idx] + 1 : 3;
        m_targets[idx] = m_upd.target;
      end else if (idx >= 0) begin
        m_counter[idx] = (m_counter[idx] > 0) ? m_counter[idx] - 1 : 0;
      end else begin
        m_keys[m_ptr] = m_upd.key;
        m_targets[m_ptr] = m_upd.target;
        m_counter[m_ptr] = m_upd.taken ? 3 : 0;
        m_used[m_ptr] = 1'b1;
        m_ptr = (m_ptr + 1) % entries;
      end
    end
    correct = res.taken ? res.target : res.pc + 4;
    guessed = res.pred_taken ? res.pred_target : res.pc + 4;
    m_upd_valid = strobe;
    m_redir_valid = strobe && (correct != guessed);
    if (strobe) begin
      m_upd.key = res.pc;
      m_upd.target = res.target;
      m_upd.taken = res.taken;
      m_redir_pc = correct;
    end
  endtask

  initial begin
    logic [31:0]           r;
    logic                  pt;
    logic [addr_width-1:0] ptgt;
    int                    errors_before;
    pass_count = 0;
    fail_count = 0;
    errors_before = 0;
    seed = 77;
    apply_reset();
    for (int row = 0; row < num_rows; row++) begin
      fetch_en = cases[row].fetch_en;
      resolve_strobe = cases[row].res_strobe;
      resolve = cases[row].res;
      #(clk_period - 2 * drive_delay);
      check_fetch(row, cases[row].exp_pc, cases[row].exp_taken, cases[row].exp_target);
      if (row == num_rows - 1 || cases[row + 1].test_id != cases[row].test_id) begin
        report_test(int'(cases[row].test_id), errors_before);
        errors_before = fail_count;
      end
      @(posedge clk);
      #drive_delay;
    end
    // random stream starts from a fresh reset so the model starts empty
    apply_reset();
    model_reset();
    for (int i = 0; i < random_steps; i++) begin
      r = $random(seed);
      fetch_en = (r[2:0] != 3'd0);
      resolve_strobe = (r[4:3] == 2'd0);
      resolve = '0;
      if (resolve_strobe) begin
        resolve.pc = 32'h40 + {26'd0, r[8:5], 2'b00};
        resolve.target = 32'h40 + {26'd0, r[12:9], 2'b00};
        resolve.taken = r[13];
        // prediction as fetch would have made it for this pc
        model_predict(resolve.pc, resolve.pred_taken, resolve.pred_target);
      end
      #(clk_period - 2 * drive_delay);
      model_predict(m_pc, pt, ptgt);
      check_fetch(num_rows + i, m_pc, pt, ptgt);
      model_step(fetch_en, resolve_strobe, resolve);
      @(posedge clk);
      #drive_delay;
    end
    report_test(6, errors_before);
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- bpred.f
+incdir+bench
logic/bpred_pkg.sv
logic/match_encoder.sv
logic/target_buffer.sv
logic/resolve_unit.sv
logic/fetch_pc.sv
logic/bpred_top.sv
bench/bpred_tb.sv

//--- logic/bpred_pkg.sv
package bpred_pkg;

  localparam int default_addr_width = 32;
  localparam int default_entries = 8;

  // 2-bit saturating branch counter, upper half predicts taken
  typedef enum logic [1:0] {
    strong_not   = 2'b00,
    weak_not     = 2'b01,
    weak_taken   = 2'b10,
    strong_taken = 2'b11
  } pred_state_t;

  // one fetch, carried back by execute with the resolved branch
  typedef struct packed {
    logic [default_addr_width-1:0] pc;
    logic                          pred_taken;
    logic [default_addr_width-1:0] pred_target;
  } fetch_t;

  typedef struct packed {
    logic [default_addr_width-1:0] pc;
    logic [default_addr_width-1:0] target;
    logic                          taken;
    logic                          pred_taken;
    logic [default_addr_width-1:0] pred_target;
  } resolve_t;

  typedef struct packed {
    logic [default_addr_width-1:0] key;
    logic [default_addr_width-1:0] target;
    logic                          taken;
  } update_t;

  // one step toward the observed outcome, saturating at both ends
  function automatic pred_state_t next_state(pred_state_t state, logic taken);
    pred_state_t result;
    case (state)
      strong_not:   result = taken ? weak_not     : strong_not;
      weak_not:     result = taken ? weak_taken   : strong_not;
      weak_taken:   result = taken ? strong_taken : weak_not;
      default:      result = taken ? strong_taken : weak_taken;
    endcase
    return result;
  endfunction

endpackage

//--- logic/bpred_top.sv
`timescale 1ns/1ps

module bpred_top #(
  parameter int                    addr_width = bpred_pkg::default_addr_width,
  parameter int                    entries    = bpred_pkg::default_entries,
  parameter logic [addr_width-1:0] reset_pc   = '0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fetch_en,

  input  logic                 resolve_strobe,
  input  bpred_pkg::resolve_t  resolve,

  output logic                 fetch_strobe,
  output bpred_pkg::fetch_t    fetch
);

  // fetch to table
  logic [addr_width-1:0] lookup_pc;
  logic                  lookup_taken;
  logic [addr_width-1:0] lookup_target;

  // resolve back to table and fetch
  logic                  update_strobe;
  bpred_pkg::update_t    update;
  logic                  redirect_strobe;
  logic [addr_width-1:0] redirect_pc;

  fetch_pc #(
    .addr_width (addr_width),
    .reset_pc   (reset_pc)
  ) fetch0 (
    .clk             (clk),
    .reset           (reset),
    .fetch_en        (fetch_en),
    .redirect_strobe (redirect_strobe),
    .redirect_pc     (redirect_pc),
    .lookup_taken    (lookup_taken),
    .lookup_target   (lookup_target),
    .lookup_pc       (lookup_pc),
    .fetch_strobe    (fetch_strobe),
    .fetch           (fetch)
  );

  target_buffer #(
    .addr_width (addr_width),
    .entries    (entries)
  ) btb0 (
    .clk           (clk),
    .reset         (reset),
    .lookup_pc     (lookup_pc),
    .lookup_taken  (lookup_taken),
    .lookup_target (lookup_target),
    .update_strobe (update_strobe),
    .update        (update)
  );

  resolve_unit #(
    .addr_width (addr_width)
  ) resolve0 (
    .clk             (clk),
    .reset           (reset),
    .resolve_strobe  (resolve_strobe),
    .resolve         (resolve),
    .update_strobe   (update_strobe),
    .update          (update),
    .redirect_strobe (redirect_strobe),
    .redirect_pc     (redirect_pc)
  );

endmodule

//--- logic/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc #(
  parameter int                    addr_width = bpred_pkg::default_addr_width,
  parameter logic [addr_width-1:0] reset_pc   = '0
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetch_en,

  input  logic                   redirect_strobe,
  input  logic [addr_width-1:0]  redirect_pc,

  input  logic                   lookup_taken,
  input  logic [addr_width-1:0]  lookup_target,
  output logic [addr_width-1:0]  lookup_pc,

  output logic                   fetch_strobe,
  output bpred_pkg::fetch_t      fetch
);

  logic [addr_width-1:0] pc;
  logic [addr_width-1:0] next_pc;

  assign lookup_pc = pc;

  // redirect first, then the table's guess, then sequential
  always_comb begin
    if (redirect_strobe) begin
      next_pc = redirect_pc;
    end else if (lookup_taken) begin
      next_pc = lookup_target;
    end else begin
      next_pc = pc + addr_width'(4);
    end
  end

  // a redirect lands even while fetch is stalled
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (fetch_en || redirect_strobe) begin
      pc <= next_pc;
    end
  end

  assign fetch_strobe      = fetch_en;
  assign fetch.pc          = pc;
  assign fetch.pred_taken  = lookup_taken;
  assign fetch.pred_target = lookup_target;

endmodule

//--- logic/match_encoder.sv
`timescale 1ns/1ps

module match_encoder #(
  parameter int entries = bpred_pkg::default_entries
) (
  input  logic [entries-1:0]         match,
  output logic [$clog2(entries)-1:0] index,
  output logic                       any
);

  localparam int index_width = $clog2(entries);

  // walk from the top down so the lowest set bit wins
  always_comb begin
    index = '0;
    for (int i = entries - 1; i >= 0; i--) begin
      if (match[i]) begin
        index = index_width'(i);
      end
    end
  end

  assign any = |match;

endmodule

//--- logic/resolve_unit.sv
`timescale 1ns/1ps

module resolve_unit #(
  parameter int addr_width = bpred_pkg::default_addr_width
) (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   resolve_strobe,
  input  bpred_pkg::resolve_t    resolve,

  output logic                   update_strobe,
  output bpred_pkg::update_t     update,

  output logic                   redirect_strobe,
  output logic [addr_width-1:0]  redirect_pc
);

  logic [addr_width-1:0] fall_through;
  logic [addr_width-1:0] correct_next;
  logic [addr_width-1:0] predicted_next;
  logic                  mispredict;

  assign fall_through = resolve.pc + addr_width'(4);

  // where fetch should have gone, and where it actually went
  assign correct_next   = resolve.taken ? resolve.target : fall_through;
  assign predicted_next = resolve.pred_taken ? resolve.pred_target : fall_through;

  // a taken prediction with the right target still counts as correct
  assign mispredict = (correct_next != predicted_next);

  // strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      update_strobe   <= 1'b0;
      redirect_strobe <= 1'b0;
    end else begin
      update_strobe   <= resolve_strobe;
      redirect_strobe <= resolve_strobe && mispredict;
    end
  end

  // payload follows the strobe, only meaningful when it is high
  always_ff @(posedge clk) begin
    if (resolve_strobe) begin
      update.key    <= resolve.pc;
      update.target <= resolve.target;
      update.taken  <= resolve.taken;
      redirect_pc   <= correct_next;
    end
  end

endmodule

//--- logic/target_buffer.sv
`timescale 1ns/1ps

module target_buffer #(
  parameter int addr_width = bpred_pkg::default_addr_width,
  parameter int entries    = bpred_pkg::default_entries
) (
  input  logic                    clk,
  input  logic                    reset,

  input  logic [addr_width-1:0]   lookup_pc,
  output logic                    lookup_taken,
  output logic [addr_width-1:0]   lookup_target,

  input  logic                    update_strobe,
  input  bpred_pkg::update_t      update
);

  localparam int index_width = $clog2(entries);

  // table contents
  logic [addr_width-1:0]  keys    [entries];
  logic [addr_width-1:0]  targets [entries];
  bpred_pkg::pred_state_t states  [entries];
  logic [entries-1:0]     occupied;

  // round-robin victim for misses
  logic [index_width-1:0] alloc_ptr;
  logic [index_width-1:0] next_ptr;

  logic [entries-1:0]     lookup_match;
  logic [index_width-1:0] lookup_index;
  logic                   lookup_hit;
  bpred_pkg::pred_state_t lookup_state;

  logic [entries-1:0]     update_match;
  logic [index_width-1:0] update_index;
  logic                   update_hit;
  bpred_pkg::pred_state_t alloc_state;

  // only occupied entries may match, so a cleared key of 0 is harmless
  always_comb begin
    for (int i = 0; i < entries; i++) begin
      lookup_match[i] = occupied[i] && (keys[i] == lookup_pc);
      update_match[i] = occupied[i] && (keys[i] == update.key);
    end
  end

  match_encoder #(
    .entries (entries)
  ) lookup_enc (
    .match (lookup_match),
    .index (lookup_index),
    .any   (lookup_hit)
  );

  match_encoder #(
    .entries (entries)
  ) update_enc (
    .match (update_match),
    .index (update_index),
    .any   (update_hit)
  );

  // combinational lookup, sees contents before this cycle's update
  assign lookup_state = states[lookup_index];
  assign lookup_taken = lookup_hit &&
                        (lookup_state == bpred_pkg::weak_taken ||
                         lookup_state == bpred_pkg::strong_taken);
  assign lookup_target = lookup_hit ? targets[lookup_index] : '0;

  // new entries start strong in the observed direction
  assign alloc_state = update.taken ? bpred_pkg::strong_taken : bpred_pkg::strong_not;

  assign next_ptr = (alloc_ptr == index_width'(entries - 1)) ? '0 : alloc_ptr + 1'b1;

  // counters, occupied bits and pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      occupied  <= '0;
      alloc_ptr <= '0;
      for (int i = 0; i < entries; i++) begin
        states[i] <= bpred_pkg::strong_not;
      end
    end else if (update_strobe) begin
      if (update_hit) begin
        states[update_index] <= bpred_pkg::next_state(states[update_index], update.taken);
      end else begin
        states[alloc_ptr]   <= alloc_state;
        occupied[alloc_ptr] <= 1'b1;
        alloc_ptr           <= next_ptr;
      end
    end
  end

  // keys and targets
  always_ff @(posedge clk) begin
    if (update_strobe) begin
      if (!update_hit) begin
        keys[alloc_ptr]    <= update.key;
        targets[alloc_ptr] <= update.target;
      end else if (update.taken) begin
        // not-taken outcomes keep the old target
        targets[update_index] <= update.target;
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the passing line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module bpred_tb -Mdir obj_dir -f bpred.f \
  && ./obj_dir/Vbpred_tb | tee /dev/stderr | grep -qx "Finished with no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
